// ==== tb.f ====
+incdir+include
+incdir+tb
source/fma_mem_pkg.sv
source/mem_instr_decoder.sv
source/line_assembler.sv
source/line_ram.sv
source/fma_line_memory.sv
tb/tb_fma_line_memory.sv

// ==== Bender.yml ====
package:
  name: fma_line_memory

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/fma_mem_pkg.sv
      - source/mem_instr_decoder.sv
      - source/line_assembler.sv
      - source/line_ram.sv
      - source/fma_line_memory.sv

  - target: test
    include_dirs:
      - include
      - tb
    files:
      - tb/tb_fma_line_memory.sv

// ==== tb/tb_fma_mem_model.svh ====
`ifndef TB_FMA_MEM_MODEL_SVH
`define TB_FMA_MEM_MODEL_SVH

// ------------------------------
// model state
// ------------------------------

// one outstanding WRITEB result
typedef struct packed {
    fma_mem_pkg::line_t line;
    logic [1:0]         flags;    // use_new_c, output can be valid
    logic [31:0]        edge_no;  // edge after which the pulse is due
} expect_t;

fma_mem_pkg::line_t      model_stage;
fma_mem_pkg::line_t      model_captured;
fma_mem_pkg::line_addr_t model_held;
fma_mem_pkg::line_t      model_mem [`FMA_MEM_DEPTH];
expect_t                 expect_q [$];  // filled at drive time, drained by the compare process
int                      errors = 0;
int                      checks = 0;

// word k sits k slices below the top of the line
function automatic fma_mem_pkg::line_t set_word(input fma_mem_pkg::line_t l, input int k,
                                                input fma_mem_pkg::word_t w);
    fma_mem_pkg::line_t r;
    r = l;
    r[`FMA_MEM_LINE_W - 1 - k * `FMA_MEM_WORD_W -: `FMA_MEM_WORD_W] = w;
    return r;
endfunction

// expected line and flags for a WRITEB, due two edges after accept
function automatic expect_t read_result(input fma_mem_pkg::line_addr_t addr,
                                        input fma_mem_pkg::word_idx_t a,
                                        input fma_mem_pkg::word_idx_t b, input int accept_edge);
    expect_t e;
    e.line    = model_mem[addr];
    e.flags   = {a == 4'd1, b == 4'd1};  // only code 1 sets a flag
    e.edge_no = accept_edge + 2;
    return e;
endfunction

// one accepted instruction, applied in accept order
task automatic apply_to_model(input fma_mem_pkg::instr_t ins, input fma_mem_pkg::word_t ra,
                              input fma_mem_pkg::word_t rb, input fma_mem_pkg::word_t rc,
                              input int accept_edge);
    logic [3:0]              op;
    fma_mem_pkg::word_idx_t  a;
    fma_mem_pkg::word_idx_t  b;
    fma_mem_pkg::word_t      imm;
    fma_mem_pkg::word_t      src;
    fma_mem_pkg::line_addr_t addr;
    op   = ins[31:28];
    a    = ins[27:24];
    imm  = ins[23:8];
    b    = ins[7:4];
    addr = imm[`FMA_MEM_ADDR_W-1:0];  // upper immediate bits carry no address
    case (op)
        fma_mem_pkg::OP_SMA:   model_held = addr;
        fma_mem_pkg::OP_LOADI: if (a < 6) model_stage = set_word(model_stage, a, imm);
        fma_mem_pkg::OP_SENDL: model_mem[model_held] = model_stage;
        fma_mem_pkg::OP_LOADB: begin
            model_held      = addr;
            model_mem[addr] = model_captured;
        end
        fma_mem_pkg::OP_WRITEB: begin
            model_held = addr;
            expect_q.push_back(read_result(addr, a, b, accept_edge));
        end
        fma_mem_pkg::OP_LOAD: if (a < 3) begin
            src = (b == 4'd0) ? ra : ((b == 4'd1) ? rb : rc);
            for (int i = 0; i < 2; i++) begin
                model_stage = set_word(model_stage, 3 * i + a, src + fma_mem_pkg::word_t'(i) * imm);
            end
        end
        default: ;  // everything else is a no-op for the memory
    endcase
endtask

// ------------------------------
// compare tasks
// ------------------------------

task automatic check_line(input string name, input fma_mem_pkg::line_t exp_line,
                          input fma_mem_pkg::line_t act_line);
    checks++;
    if (act_line !== exp_line) begin
        errors++;
        $display("[FAIL] %s line expected %h actual %h", name, exp_line, act_line);
    end
endtask

task automatic check_flags(input string name, input logic [1:0] exp_flags,
                           input logic [1:0] act_flags);
    checks++;
    if (act_flags !== exp_flags) begin
        errors++;
        $display("[FAIL] %s flags expected %b actual %b", name, exp_flags, act_flags);
    end
endtask

`endif

// ==== tb/tb_fma_line_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fma_mem_cfg.svh"

module tb_fma_line_memory;

    localparam int POOL_N      = 4;   // lines the stream reads back
    localparam int STREAM_N    = 60;  // random steps in the last test
    localparam int STEPS       = 9 + 9 + 9 + 2 * POOL_N + STREAM_N;
    localparam int CYCLE_LIMIT = STEPS * 4 + 200;  // generous per step, plus reset and drains

    logic                    clk_in;
    logic                    rst_in;
    fma_mem_pkg::instr_t     instr_in;
    logic                    instr_valid_in;
    fma_mem_pkg::line_t      write_buffer_read_in;
    logic                    write_buffer_valid_in;
    fma_mem_pkg::word_t      controller_reg_a;
    fma_mem_pkg::word_t      controller_reg_b;
    fma_mem_pkg::word_t      controller_reg_c;
    fma_mem_pkg::line_t      abc_out;
    logic                    abc_valid_out;
    logic                    use_new_c_out;
    logic                    fma_output_can_be_valid_out;
    integer                  seed;
    int                      edge_count;
    string                   cur_test;
    int                      test_err_start;
    fma_mem_pkg::line_addr_t pool [POOL_N];
    fma_mem_pkg::line_addr_t addr;
    logic [31:0]             rnd;
    logic [2:0]              kind;
    logic [1:0]              flags;

    `include "tb_fma_mem_model.svh"

    fma_line_memory uut (
        .clk_in                      (clk_in),
        .rst_in                      (rst_in),
        .instr_in                    (instr_in),
        .instr_valid_in              (instr_valid_in),
        .write_buffer_read_in        (write_buffer_read_in),
        .write_buffer_valid_in       (write_buffer_valid_in),
        .controller_reg_a            (controller_reg_a),
        .controller_reg_b            (controller_reg_b),
        .controller_reg_c            (controller_reg_c),
        .abc_out                     (abc_out),
        .abc_valid_out               (abc_valid_out),
        .use_new_c_out               (use_new_c_out),
        .fma_output_can_be_valid_out (fma_output_can_be_valid_out)
    );

    always #2 clk_in = ~clk_in;  // 4 ns period

    always @(posedge clk_in) begin
        edge_count <= edge_count + 1;
        if (edge_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in %s, results still missing", edge_count, cur_test);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    function automatic fma_mem_pkg::instr_t make_instr(input logic [3:0] op,
            input fma_mem_pkg::word_idx_t a, input fma_mem_pkg::word_t imm,
            input fma_mem_pkg::word_idx_t b);
        return {op, a, imm, b, 4'h0};  // C field unused by the memory
    endfunction

    // controller registers get fresh values with every instruction
    task automatic issue(input fma_mem_pkg::instr_t ins);
        logic [31:0]        r;
        fma_mem_pkg::word_t ra;
        fma_mem_pkg::word_t rb;
        fma_mem_pkg::word_t rc;
        r  = $random(seed);
        ra = r[15:0];
        rb = r[31:16];
        r  = $random(seed);
        rc = r[15:0];
        @(posedge clk_in);
        instr_in              <= ins;
        instr_valid_in        <= 1'b1;
        write_buffer_valid_in <= 1'b0;
        controller_reg_a      <= ra;
        controller_reg_b      <= rb;
        controller_reg_c      <= rc;
        apply_to_model(ins, ra, rb, rc, edge_count + 2);  // accepted on the next edge
    endtask

    task automatic capture_line(input fma_mem_pkg::line_t l);
        @(posedge clk_in);
        write_buffer_read_in  <= l;
        write_buffer_valid_in <= 1'b1;
        instr_valid_in        <= 1'b0;
        model_captured = l;
    endtask

    task automatic idle_cycle();
        @(posedge clk_in);
        instr_valid_in        <= 1'b0;
        write_buffer_valid_in <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    // waits for every outstanding read, the timeout catches a lost pulse
    task automatic end_test();
        idle_cycle();
        while (expect_q.size() != 0) idle_cycle();
        repeat (2) idle_cycle();
        if (errors == test_err_start) $display("%s: ok", cur_test);
        else $display("%s: %0d errors", cur_test, errors - test_err_start);
    endtask

    // ------------------------------
    // compare process
    // ------------------------------

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk_in) begin : compare_results
        expect_t exp_item;
        if (!rst_in && abc_valid_out === 1'b1) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("unexpected result in %s, valid pulse with no read outstanding", cur_test);
            end else begin
                exp_item = expect_q.pop_front();
                check_line(cur_test, exp_item.line, abc_out);
                check_flags(cur_test, exp_item.flags, {use_new_c_out, fma_output_can_be_valid_out});
                if (edge_count != exp_item.edge_no) begin
                    errors++;
                    $display("%s result came after edge %0d instead of edge %0d", cur_test,
                             edge_count, exp_item.edge_no);
                end
            end
        end
    end

    // ------------------------------
    // tests
    // ------------------------------

    initial begin
        clk_in                = 1'b0;
        rst_in                = 1'b1;
        instr_in              = '0;
        instr_valid_in        = 1'b0;
        write_buffer_read_in  = '0;
        write_buffer_valid_in = 1'b0;
        controller_reg_a      = '0;
        controller_reg_b      = '0;
        controller_reg_c      = '0;
        seed                  = 32'h8f4e_b1db;
        edge_count            = 0;
        cur_test              = "reset";
        model_stage           = '0;  // same reset state as the staging register
        model_captured        = '0;
        model_held            = '0;
        repeat (16) @(posedge clk_in);
        rst_in <= 1'b0;

        begin_test("idle_outputs_zero");
        repeat (20) begin
            @(negedge clk_in);
            check_line(cur_test, '0, abc_out);
            check_flags(cur_test, 2'b00, {use_new_c_out, fma_output_can_be_valid_out});
            if (abc_valid_out !== 1'b0) begin
                errors++;
                $display("%s saw a valid pulse before any read", cur_test);
            end
        end
        end_test();

        begin_test("loadi_sendl_writeb");
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            issue(make_instr(fma_mem_pkg::OP_LOADI, k[3:0], rnd[15:0], 4'h0));
        end
        rnd  = $random(seed);
        addr = rnd[8:0];
        issue(make_instr(fma_mem_pkg::OP_SMA, 4'h0, {rnd[31:25], addr}, 4'h0));
        issue(make_instr(fma_mem_pkg::OP_SENDL, 4'h0, 16'h0000, 4'h0));
        issue(make_instr(fma_mem_pkg::OP_WRITEB, 4'h0, {7'h00, addr}, 4'h1));
        end_test();

        begin_test("load_step_and_bad_index");
        for (int s = 0; s < 3; s++) begin
            rnd = $random(seed);  // low half is the per-FMA step
            issue(make_instr(fma_mem_pkg::OP_LOAD, s[3:0], rnd[15:0], (s == 2) ? 4'd6 : s[3:0]));
        end
        rnd = $random(seed);
        issue(make_instr(fma_mem_pkg::OP_LOADI, 4'd6, rnd[15:0], 4'h0));
        issue(make_instr(fma_mem_pkg::OP_LOADI, 4'd15, rnd[31:16], 4'h0));
        issue(make_instr(fma_mem_pkg::OP_LOAD, 4'd3, rnd[23:8], 4'h0));
        addr = rnd[8:0];
        issue(make_instr(fma_mem_pkg::OP_SMA, 4'h0, {7'h00, addr}, 4'h0));
        issue(make_instr(fma_mem_pkg::OP_SENDL, 4'h0, 16'h0000, 4'h0));
        issue(make_instr(fma_mem_pkg::OP_WRITEB, 4'h1, {7'h00, addr}, 4'h0));
        end_test();

        begin_test("loadb_roundtrip");
        repeat (3) begin
            rnd  = $random(seed);
            addr = rnd[8:0];
            capture_line({$random(seed), $random(seed), $random(seed)});
            issue(make_instr(fma_mem_pkg::OP_LOADB, 4'h0, {rnd[31:25], addr}, 4'h0));
            issue(make_instr(fma_mem_pkg::OP_WRITEB, rnd[12:9], {rnd[31:25], addr}, rnd[16:13]));
        end
        end_test();

        begin_test("writeb_stream");
        for (int j = 0; j < POOL_N; j++) begin
            rnd     = $random(seed);
            pool[j] = rnd[8:0];  // only these lines are read, so nothing comes back undefined
            issue(make_instr(fma_mem_pkg::OP_SMA, 4'h0, {7'h00, pool[j]}, 4'h0));
            issue(make_instr(fma_mem_pkg::OP_SENDL, 4'h0, 16'h0000, 4'h0));
        end
        for (int n = 0; n < STREAM_N; n++) begin
            rnd  = $random(seed);
            kind = (n < 4) ? 3'd0 : rnd[2:0];  // opening reads walk all four flag codes
            addr = pool[rnd[4:3]];
            case (kind)
                3'd0, 3'd1, 3'd2, 3'd3: begin
                    flags = (n < 4) ? n[1:0] : rnd[6:5];
                    issue(make_instr(fma_mem_pkg::OP_WRITEB,
                                     flags[1] ? 4'd1 : {rnd[10:8], 1'b0}, {7'h00, addr},
                                     flags[0] ? 4'd1 : {rnd[13:11], 1'b0}));
                end
                3'd4: issue(make_instr(fma_mem_pkg::OP_SENDL, 4'h0, 16'h0000, 4'h0));
                3'd5: issue(make_instr(fma_mem_pkg::OP_LOADB, 4'h0, {7'h00, addr}, 4'h0));
                3'd6: issue(make_instr(fma_mem_pkg::OP_LOADI, {1'b0, rnd[9:7]}, rnd[31:16], 4'h0));
                default: capture_line({$random(seed), $random(seed), $random(seed)});
            endcase
        end
        end_test();

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/fma_line_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module fma_line_memory (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  fma_mem_pkg::instr_t   instr_in,
    input  logic                  instr_valid_in,
    input  fma_mem_pkg::line_t    write_buffer_read_in,
    input  logic                  write_buffer_valid_in,
    input  fma_mem_pkg::word_t    controller_reg_a,
    input  fma_mem_pkg::word_t    controller_reg_b,
    input  fma_mem_pkg::word_t    controller_reg_c,
    output fma_mem_pkg::line_t    abc_out,
    output logic                  abc_valid_out,
    output logic                  use_new_c_out,
    output logic                  fma_output_can_be_valid_out
);

    fma_mem_pkg::mem_cmd_t cmd;      // decoded in the accept cycle
    fma_mem_pkg::ram_req_t ram_req;  // registered one edge after accept

    // ------------------------------
    // decode, assemble, store
    // ------------------------------

    mem_instr_decoder u_decoder (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .instr_in       (instr_in),
        .instr_valid_in (instr_valid_in),
        .cmd            (cmd)
    );

    line_assembler u_assembler (
        .clk_in                (clk_in),
        .rst_in                (rst_in),
        .cmd                   (cmd),
        .write_buffer_read_in  (write_buffer_read_in),
        .write_buffer_valid_in (write_buffer_valid_in),
        .controller_reg_a      (controller_reg_a),
        .controller_reg_b      (controller_reg_b),
        .controller_reg_c      (controller_reg_c),
        .ram_req               (ram_req)
    );

    // WRITEB accepted at T shows up on the outputs after T+2
    line_ram u_ram (
        .clk_in                      (clk_in),
        .rst_in                      (rst_in),
        .ram_req                     (ram_req),
        .abc_out                     (abc_out),
        .abc_valid_out               (abc_valid_out),
        .use_new_c_out               (use_new_c_out),
        .fma_output_can_be_valid_out (fma_output_can_be_valid_out)
    );

endmodule

`default_nettype wire

// ==== source/line_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fma_mem_cfg.svh"

module line_ram (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  fma_mem_pkg::ram_req_t ram_req,
    output fma_mem_pkg::line_t    abc_out,
    output logic                  abc_valid_out,
    output logic                  use_new_c_out,
    output logic                  fma_output_can_be_valid_out
);

    fma_mem_pkg::line_t mem [`FMA_MEM_DEPTH];  // contents are undefined after reset
    fma_mem_pkg::line_t rd_data;               // read register, first stage
    logic               rd_pending;            // a read result sits in rd_data
    logic               use_new_c_pending;
    logic               out_valid_pending;

    // ------------------------------
    // array, read-first
    // ------------------------------

    always_ff @(posedge clk_in) begin
        if (ram_req.wr_en) begin
            mem[ram_req.addr] <= ram_req.wdata;
        end
        rd_data <= mem[ram_req.addr];  // old contents on a write edge, never used then
    end

    // strobe and flags follow the data through the first stage
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_pending        <= 1'b0;
            use_new_c_pending <= 1'b0;
            out_valid_pending <= 1'b0;
        end else begin
            rd_pending        <= ram_req.rd_en;
            use_new_c_pending <= ram_req.use_new_c;
            out_valid_pending <= ram_req.out_valid;
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            abc_out                     <= '0;
            abc_valid_out               <= 1'b0;
            use_new_c_out               <= 1'b0;
            fma_output_can_be_valid_out <= 1'b0;
        end else begin
            abc_valid_out <= rd_pending;  // one cycle pulse per read
            if (rd_pending) begin
                // line and flags hold until the next read result
                abc_out                     <= rd_data;
                use_new_c_out               <= use_new_c_pending;
                fma_output_can_be_valid_out <= out_valid_pending;
            end
        end
    end

    // each pulse to the FMAs traces back to a read request two edges earlier
    valid_after_read_a : assert property (
        @(posedge clk_in) disable iff (rst_in) abc_valid_out |-> $past(ram_req.rd_en, 2)
    ) else $error("abc_valid_out without a read two edges before");

endmodule

`default_nettype wire

// ==== source/line_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fma_mem_cfg.svh"

module line_assembler (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  fma_mem_pkg::mem_cmd_t cmd,
    input  fma_mem_pkg::line_t    write_buffer_read_in,
    input  logic                  write_buffer_valid_in,
    input  fma_mem_pkg::word_t    controller_reg_a,
    input  fma_mem_pkg::word_t    controller_reg_b,
    input  fma_mem_pkg::word_t    controller_reg_c,
    output fma_mem_pkg::ram_req_t ram_req
);

    localparam int FMA_COUNT     = `FMA_MEM_FMA_COUNT;
    localparam int SLOTS_PER_FMA = `FMA_MEM_WORDS_PER_LINE / `FMA_MEM_FMA_COUNT;
    localparam int WORD_W        = `FMA_MEM_WORD_W;
    localparam int LINE_W        = `FMA_MEM_LINE_W;

    fma_mem_pkg::line_t     staging_line;   // line being built by LOADI and LOAD
    fma_mem_pkg::line_t     captured_line;  // last line offered by the result buffer
    fma_mem_pkg::word_t     load_src;       // controller register chosen by field B
    fma_mem_pkg::word_t     load_word [FMA_COUNT];
    fma_mem_pkg::ram_req_t  req_next;

    // ------------------------------
    // LOAD arithmetic
    // ------------------------------

    always_comb begin
        case (cmd.b_field)
            4'd0:    load_src = controller_reg_a;
            4'd1:    load_src = controller_reg_b;
            default: load_src = controller_reg_c;  // any other code picks c
        endcase
    end

    // FMA i gets reg + i * step, wrapping at 16 bits
    always_comb begin
        for (int i = 0; i < FMA_COUNT; i++) begin
            load_word[i] = load_src + fma_mem_pkg::word_t'(i) * cmd.imm;
        end
    end

    // ------------------------------
    // staging and captured lines
    // ------------------------------

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            staging_line <= '0;
        end else if (cmd.valid) begin
            case (cmd.op)
                fma_mem_pkg::OP_LOADI: begin
                    // word k is counted down from the top of the line
                    staging_line[LINE_W - 1 - cmd.a_field * WORD_W -: WORD_W] <= cmd.imm;
                end
                fma_mem_pkg::OP_LOAD: begin
                    for (int i = 0; i < FMA_COUNT; i++) begin
                        staging_line[LINE_W - 1 - (i * SLOTS_PER_FMA + cmd.a_field) * WORD_W
                                     -: WORD_W] <= load_word[i];  // slot A of FMA i
                    end
                end
                default: ;  // other commands leave the staging line alone
            endcase
        end
    end

    // LOADB sees the value held before its own edge, so a capture on that edge is too late
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            captured_line <= '0;
        end else if (write_buffer_valid_in) begin
            captured_line <= write_buffer_read_in;
        end
    end

    // ------------------------------
    // RAM request
    // ------------------------------

    always_comb begin
        req_next       = '0;
        req_next.addr  = cmd.addr;
        req_next.wdata = (cmd.op == fma_mem_pkg::OP_LOADB) ? captured_line : staging_line;
        if (cmd.valid) begin
            case (cmd.op)
                fma_mem_pkg::OP_SENDL,
                fma_mem_pkg::OP_LOADB: req_next.wr_en = 1'b1;
                fma_mem_pkg::OP_WRITEB: begin
                    req_next.rd_en     = 1'b1;
                    req_next.use_new_c = (cmd.a_field == 4'd1);  // only code 1 means yes
                    req_next.out_valid = (cmd.b_field == 4'd1);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ram_req <= '0;
        end else begin
            ram_req <= req_next;  // one access per edge, issued the edge after accept
        end
    end

    // the RAM has one port, a read and a write can never share an edge
    single_access_a : assert property (
        @(posedge clk_in) disable iff (rst_in) !(ram_req.wr_en && ram_req.rd_en)
    ) else $error("RAM read and write requested together");

endmodule

`default_nettype wire

// ==== source/mem_instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fma_mem_cfg.svh"

module mem_instr_decoder (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  fma_mem_pkg::instr_t   instr_in,
    input  logic                  instr_valid_in,
    output fma_mem_pkg::mem_cmd_t cmd
);

    // each FMA owns a, b and c
    localparam int SLOTS_PER_FMA = `FMA_MEM_WORDS_PER_LINE / `FMA_MEM_FMA_COUNT;

    logic [3:0]                 op_field;
    fma_mem_pkg::word_idx_t     a_field;
    fma_mem_pkg::word_idx_t     b_field;
    fma_mem_pkg::word_t         imm_field;
    fma_mem_pkg::line_addr_t    imm_addr;
    fma_mem_pkg::line_addr_t    held_addr;  // address that SENDL writes to
    logic                       op_legal;
    logic                       sets_addr;

    // ------------------------------
    // field extraction
    // ------------------------------

    assign op_field  = instr_in[31:28];
    assign a_field   = instr_in[27:24];
    assign imm_field = instr_in[23:8];
    assign b_field   = instr_in[7:4];   // the C field in 3..0 has no meaning here

    assign imm_addr = imm_field[`FMA_MEM_ADDR_W-1:0];  // upper immediate bits are ignored

    // unknown opcodes and out of range indices fall through as NOP
    always_comb begin
        op_legal  = 1'b0;
        sets_addr = 1'b0;
        case (op_field)
            fma_mem_pkg::OP_SMA,
            fma_mem_pkg::OP_LOADB,
            fma_mem_pkg::OP_WRITEB: begin
                op_legal  = 1'b1;
                sets_addr = 1'b1;  // these carry their own line address
            end
            fma_mem_pkg::OP_SENDL: op_legal = 1'b1;
            fma_mem_pkg::OP_LOADI: op_legal = (a_field < `FMA_MEM_WORDS_PER_LINE);
            fma_mem_pkg::OP_LOAD:  op_legal = (a_field < SLOTS_PER_FMA);
            default:               op_legal = 1'b0;  // NOP and the controller-only opcodes
        endcase
    end

    // ------------------------------
    // command out
    // ------------------------------

    always_comb begin
        cmd.valid   = instr_valid_in && op_legal;
        cmd.op      = op_legal ? fma_mem_pkg::mem_op_e'(op_field) : fma_mem_pkg::OP_NOP;
        cmd.a_field = a_field;
        cmd.imm     = imm_field;
        cmd.b_field = b_field;
        cmd.addr    = sets_addr ? imm_addr : held_addr;  // SENDL goes to the held address
    end

    // the held address follows every instruction that names a line
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            held_addr <= '0;
        end else if (cmd.valid && sets_addr) begin
            held_addr <= imm_addr;
        end
    end

    // once out of reset the held address must stay known, or SENDL writes to nowhere
    held_addr_known_a : assert property (
        @(posedge clk_in) disable iff (rst_in) !$isunknown(held_addr)
    ) else $error("held line address went unknown");

endmodule

`default_nettype wire

// ==== source/fma_mem_pkg.sv ====
`include "fma_mem_cfg.svh"

package fma_mem_pkg;

    // ------------------------------
    // plain vectors
    // ------------------------------

    typedef logic [`FMA_MEM_WORD_W-1:0]  word_t;      // one FMA operand
    typedef logic [`FMA_MEM_LINE_W-1:0]  line_t;      // word 0 sits in the top slice
    typedef logic [`FMA_MEM_ADDR_W-1:0]  line_addr_t; // RAM line address
    typedef logic [3:0]                  word_idx_t;  // word or slot index from a field
    typedef logic [`FMA_MEM_INSTR_W-1:0] instr_t;     // op | A | imm | B | C

    // opcode values follow the controller ISA, the ALU and branch codes are not ours
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_SMA    = 4'd6,  // set the held line address
        OP_LOADI  = 4'd7,  // immediate into word A of the staging line
        OP_SENDL  = 4'd8,  // staging line into the RAM at the held address
        OP_LOADB  = 4'd9,  // captured FMA result line into the RAM
        OP_WRITEB = 4'd10, // RAM line out to the FMAs
        OP_LOAD   = 4'd13  // controller register plus per-FMA step into slot A
    } mem_op_e;

    // ------------------------------
    // request structs
    // ------------------------------

    // decoded command, valid only for a legal accepted instruction
    typedef struct packed {
        logic       valid;
        mem_op_e    op;
        word_idx_t  a_field;  // word index, slot or use-new-c code
        word_t      imm;      // immediate, also LOAD step
        word_idx_t  b_field;  // register select or output-valid code
        line_addr_t addr;     // effective line address
    } mem_cmd_t;

    // one RAM access per edge, either a write or a read
    typedef struct packed {
        logic       wr_en;
        logic       rd_en;
        line_addr_t addr;
        line_t      wdata;
        logic       use_new_c;   // WRITEB flag, travels with the read
        logic       out_valid;   // WRITEB flag, travels with the read
    } ram_req_t;

endpackage

// ==== include/fma_mem_cfg.svh ====
`ifndef FMA_MEM_CFG_SVH
`define FMA_MEM_CFG_SVH

// ------------------------------
// operand and line geometry
// ------------------------------

`define FMA_MEM_WORD_W          16  // one operand word
`define FMA_MEM_FMA_COUNT       2   // FMAs fed by one line
`define FMA_MEM_WORDS_PER_LINE  6   // a, b and c for each FMA

// whole line, six words packed from the most significant end
`define FMA_MEM_LINE_W          ((`FMA_MEM_WORDS_PER_LINE) * (`FMA_MEM_WORD_W))

// ------------------------------
// storage and instruction sizes
// ------------------------------

`define FMA_MEM_ADDR_W          9   // line address, covers every line of the RAM
`define FMA_MEM_DEPTH           512 // lines held in the RAM
`define FMA_MEM_INSTR_W         32  // controller instruction word

`endif
